// File: calc_pkg.sv
// ------------------------------
// Integer execute core types
// 32 x 64 bit register file, x0 reads as zero
// Four execute stages with static latencies
// ------------------------------
`default_nettype none

package calc_pkg;

  localparam int dword_width_gp    = 64;
  localparam int reg_addr_width_gp = 5;
  localparam int pc_width_gp       = 39;
  // EX1 through EX4
  localparam int calc_stages_gp    = 4;

  typedef enum logic [2:0]
  {
    e_int_add = 3'b000,
    e_int_sub = 3'b001,
    e_int_and = 3'b010,
    e_int_or  = 3'b011,
    e_int_xor = 3'b100,
    e_int_slt = 3'b101,
    e_int_sll = 3'b110,
    e_int_srl = 3'b111
  } calc_int_op_e;

  typedef struct packed
  {
    logic         pipe_int_v;
    logic         pipe_mul_v;
    logic         irf_w_v;
    logic         instr_v;
    logic         use_imm;
    calc_int_op_e op;
  } calc_decode_s;

  // Register values are read before dispatch
  typedef struct packed
  {
    logic                         v;
    logic                         poison;
    logic [pc_width_gp-1:0]       pc;
    logic [reg_addr_width_gp-1:0] rs1_addr;
    logic [reg_addr_width_gp-1:0] rs2_addr;
    logic [reg_addr_width_gp-1:0] rd_addr;
    calc_decode_s                 decode;
    logic [dword_width_gp-1:0]    rs1;
    logic [dword_width_gp-1:0]    rs2;
    logic [dword_width_gp-1:0]    imm;
  } calc_dispatch_pkt_s;

  typedef struct packed
  {
    logic                         v;
    logic [pc_width_gp-1:0]       pc;
    logic [reg_addr_width_gp-1:0] rd_addr;
    logic                         pipe_int_v;
    logic                         pipe_mul_v;
    logic                         irf_w_v;
    logic                         instr_v;
  } calc_stage_s;

  typedef struct packed
  {
    logic                         v;
    logic                         int_iwb_v;
    logic                         mul_iwb_v;
    logic [reg_addr_width_gp-1:0] rd_addr;
  } calc_dep_status_s;

  // Index 0 is EX1
  typedef struct packed
  {
    logic                                 ex1_v;
    calc_dep_status_s [calc_stages_gp-1:0] dep_status;
  } calc_status_s;

  typedef struct packed
  {
    logic                   v;
    logic                   instret;
    logic [pc_width_gp-1:0] pc;
    logic [pc_width_gp-1:0] npc;
  } calc_commit_pkt_s;

  typedef struct packed
  {
    logic                         rd_w_v;
    logic [reg_addr_width_gp-1:0] rd_addr;
    logic [dword_width_gp-1:0]    rd_data;
  } calc_wb_pkt_s;

  typedef struct packed
  {
    logic                         v;
    logic [reg_addr_width_gp-1:0] rd_addr;
    logic [dword_width_gp-1:0]    data;
  } calc_fwd_s;

endpackage

`default_nettype wire

// File: calc_bypass.sv
// ------------------------------
// Operand forwarding network
// fwd_i[0] is the youngest slice
// A slice is only forwarded when its v is set
// ------------------------------
`default_nettype none

module calc_bypass
  import calc_pkg::*;
  #(
    parameter int depth_p   = calc_stages_gp
  , parameter bit zero_x0_p = 1'b1
  )
  (
    input  logic [reg_addr_width_gp-1:0] rs1_addr_i
  , input  logic [reg_addr_width_gp-1:0] rs2_addr_i
  , input  logic [dword_width_gp-1:0]    rs1_i
  , input  logic [dword_width_gp-1:0]    rs2_i
  , input  calc_fwd_s [depth_p-1:0]      fwd_i
  , output logic [dword_width_gp-1:0]    rs1_o
  , output logic [dword_width_gp-1:0]    rs2_o
  );

  function automatic logic [dword_width_gp-1:0] pick_operand
    (
      input logic [reg_addr_width_gp-1:0] addr
    , input logic [dword_width_gp-1:0]    rf_data
    , input calc_fwd_s [depth_p-1:0]      fwd
    );
    logic [dword_width_gp-1:0] data;
    logic                      x0_blocked;
    data       = rf_data;
    x0_blocked = zero_x0_p && (addr == '0);
    // Oldest first, so a younger match overrides
    for (int i = depth_p-1; i >= 0; i--)
    begin
      if (fwd[i].v && (fwd[i].rd_addr == addr) && !x0_blocked)
      begin
        data = fwd[i].data;
      end
    end
    return data;
  endfunction

  assign rs1_o = pick_operand(rs1_addr_i, rs1_i, fwd_i);
  assign rs2_o = pick_operand(rs2_addr_i, rs2_i, fwd_i);

endmodule

`default_nettype wire

// File: calc_pipe_int.sv
// ------------------------------
// Integer ALU, purely combinational
// Result is sampled at the end of EX1
// slt is signed, shifts use 6 bits
// ------------------------------
`default_nettype none

module calc_pipe_int
  import calc_pkg::*;
  (
    input  calc_decode_s              decode_i
  , input  logic [dword_width_gp-1:0] rs1_i
  , input  logic [dword_width_gp-1:0] rs2_i
  , input  logic [dword_width_gp-1:0] imm_i
  , output logic [dword_width_gp-1:0] data_o
  );

  localparam int shamt_width_lp = $clog2(dword_width_gp);

  logic [dword_width_gp-1:0] src2;
  logic [shamt_width_lp-1:0] shamt;
  logic                      lt_signed;

  // Immediate forms replace rs2
  assign src2      = decode_i.use_imm ? imm_i : rs2_i;
  assign shamt     = src2[shamt_width_lp-1:0];
  assign lt_signed = $signed(rs1_i) < $signed(src2);

  always_comb
  begin
    case (decode_i.op)
      e_int_add:
        data_o = rs1_i + src2;
      e_int_sub:
        data_o = rs1_i - src2;
      e_int_and:
        data_o = rs1_i & src2;
      e_int_or:
        data_o = rs1_i | src2;
      e_int_xor:
        data_o = rs1_i ^ src2;
      e_int_slt:
        data_o = {{(dword_width_gp-1){1'b0}}, lt_signed};
      e_int_sll:
        data_o = rs1_i << shamt;
      e_int_srl:
        data_o = rs1_i >> shamt;
      default:
        data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: calc_pipe_mul.sv
// ------------------------------
// Two-stage multiplier
// Operands must be the bypassed values
// Low 64 bits are valid in EX2
// ------------------------------
`default_nettype none

module calc_pipe_mul
  import calc_pkg::*;
  (
    input  logic                      clk_i
  , input  logic                      reset_i
  , input  logic [dword_width_gp-1:0] rs1_i
  , input  logic [dword_width_gp-1:0] rs2_i
  , output logic [dword_width_gp-1:0] data_o
  );

  logic [dword_width_gp-1:0]   rs1_r, rs2_r;
  logic [2*dword_width_gp-1:0] product;

  // Operand stage, loaded as the item enters EX1
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rs1_r <= '0;
      rs2_r <= '0;
    end
    else
    begin
      rs1_r <= rs1_i;
      rs2_r <= rs2_i;
    end
  end

  assign product = rs1_r * rs2_r;

  // Low word is the same for signed and unsigned
  always_ff @(posedge clk_i)
  begin
    data_o <= product[dword_width_gp-1:0];
  end

endmodule

`default_nettype wire

// File: calc_stage_pipe.sv
// ------------------------------
// Control and poison pipe, EX1 to EX4
// Flush kills items up to EX2
// Status and forwarding see flush at once
// ------------------------------
`default_nettype none

module calc_stage_pipe
  import calc_pkg::*;
  (
    input  logic                                            clk_i
  , input  logic                                            reset_i
  , input  calc_dispatch_pkt_s                              dispatch_pkt_i
  , input  logic                                            flush_i
  , output logic [calc_stages_gp-1:0]                       fwd_v_o
  , output logic [calc_stages_gp-1:0][reg_addr_width_gp-1:0] fwd_rd_addr_o
  , output logic                                            int_done_o
  , output logic                                            mul_done_o
  , output calc_status_s                                    status_o
  , output calc_commit_pkt_s                                commit_o
  , output logic                                            wb_w_v_o
  , output logic [reg_addr_width_gp-1:0]                    wb_rd_addr_o
  );

  localparam int ex1_lp = 0;
  localparam int ex2_lp = 1;
  localparam int ex3_lp = 2;
  localparam int ex4_lp = 3;

  calc_stage_s                      stage_isd;
  calc_stage_s [calc_stages_gp-1:0] stage_r;
  logic        [calc_stages_gp:0]   poison_n;
  logic        [calc_stages_gp-1:0] poison_r;

  // Invalid dispatches carry no pipe or write bits
  always_comb
  begin
    stage_isd.v          = dispatch_pkt_i.v;
    stage_isd.pc         = dispatch_pkt_i.pc;
    stage_isd.rd_addr    = dispatch_pkt_i.rd_addr;
    stage_isd.pipe_int_v = dispatch_pkt_i.v & dispatch_pkt_i.decode.pipe_int_v;
    stage_isd.pipe_mul_v = dispatch_pkt_i.v & dispatch_pkt_i.decode.pipe_mul_v;
    stage_isd.instr_v    = dispatch_pkt_i.v & dispatch_pkt_i.decode.instr_v;
    // x0 is never written
    stage_isd.irf_w_v    = dispatch_pkt_i.v & dispatch_pkt_i.decode.irf_w_v
                           & (dispatch_pkt_i.rd_addr != '0);
  end

  // Entries 0 to 2 pick up the flush, EX3 onwards is committed
  always_comb
  begin
    poison_n[0] = dispatch_pkt_i.poison | flush_i;
    for (int i = 1; i <= calc_stages_gp; i++)
    begin
      poison_n[i] = poison_r[i-1] | (flush_i & (i <= ex3_lp));
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      stage_r  <= '0;
      poison_r <= '0;
    end
    else
    begin
      stage_r  <= {stage_r[calc_stages_gp-2:0], stage_isd};
      poison_r <= poison_n[calc_stages_gp-1:0];
    end
  end

  // Hazard view and forwarding slices per stage
  always_comb
  begin
    status_o.ex1_v = stage_r[ex1_lp].v & ~poison_r[ex1_lp];
    for (int i = 0; i < calc_stages_gp; i++)
    begin
      status_o.dep_status[i].v         = stage_r[i].v & ~poison_n[i+1];
      status_o.dep_status[i].int_iwb_v = stage_r[i].pipe_int_v & stage_r[i].irf_w_v
                                         & ~poison_n[i+1];
      status_o.dep_status[i].mul_iwb_v = stage_r[i].pipe_mul_v & stage_r[i].irf_w_v
                                         & ~poison_n[i+1];
      status_o.dep_status[i].rd_addr   = stage_r[i].rd_addr;

      fwd_v_o[i]       = stage_r[i].irf_w_v & ~poison_n[i+1];
      fwd_rd_addr_o[i] = stage_r[i].rd_addr;
    end
  end

  // Static latencies decide when each pipe finishes
  assign int_done_o = stage_r[ex1_lp].pipe_int_v;
  assign mul_done_o = stage_r[ex2_lp].pipe_mul_v;

  // Next pc is simply the younger item in EX2
  assign commit_o.v       = stage_r[ex3_lp].v & ~poison_r[ex3_lp];
  assign commit_o.instret = stage_r[ex3_lp].instr_v & ~poison_r[ex3_lp];
  assign commit_o.pc      = stage_r[ex3_lp].pc;
  assign commit_o.npc     = stage_r[ex2_lp].pc;

  assign wb_w_v_o     = stage_r[ex4_lp].irf_w_v & ~poison_r[ex4_lp];
  assign wb_rd_addr_o = stage_r[ex4_lp].rd_addr;

endmodule

`default_nettype wire

// File: calc_comp_pipe.sv
// ------------------------------
// Result completion pipe
// Single issue, so one result per stage
// Forward data is the next-state value
// ------------------------------
`default_nettype none

module calc_comp_pipe
  import calc_pkg::*;
  (
    input  logic                                          clk_i
  , input  logic [dword_width_gp-1:0]                     int_data_i
  , input  logic [dword_width_gp-1:0]                     mul_data_i
  , input  logic                                          int_done_i
  , input  logic                                          mul_done_i
  , output logic [calc_stages_gp-1:0][dword_width_gp-1:0] fwd_data_o
  , output logic [dword_width_gp-1:0]                     wb_data_o
  );

  // Entry i holds the result of the item leaving stage i-1
  logic [calc_stages_gp:1][dword_width_gp-1:0]   comp_n;
  logic [calc_stages_gp-1:1][dword_width_gp-1:0] comp_r;

  always_comb
  begin
    // Nothing is done before the end of EX1
    comp_n[1] = int_done_i ? int_data_i : '0;
    comp_n[2] = mul_done_i ? mul_data_i : comp_r[1];
    for (int i = 3; i <= calc_stages_gp; i++)
    begin
      comp_n[i] = comp_r[i-1];
    end
  end

  always_ff @(posedge clk_i)
  begin
    comp_r <= comp_n[calc_stages_gp-1:1];
  end

  // Slice 0 is EX1, the youngest
  assign fwd_data_o = comp_n;
  assign wb_data_o  = comp_r[calc_stages_gp-1];

endmodule

`default_nettype wire

// File: calculator_top.sv
// ------------------------------
// Integer execute core, no back-pressure
// Checker must hold mul consumers in EX1
// Commit in EX3, writeback in EX4
// ------------------------------
`default_nettype none

module calculator_top
  import calc_pkg::*;
  (
    input  logic               clk_i
  , input  logic               reset_i
  , input  calc_dispatch_pkt_s dispatch_pkt_i
  , input  logic               flush_i
  , output calc_status_s       calc_status_o
  , output calc_commit_pkt_s   commit_pkt_o
  , output calc_wb_pkt_s       wb_pkt_o
  );

  calc_dispatch_pkt_s reservation_n, reservation_r;

  calc_fwd_s [calc_stages_gp-1:0]                    fwd;
  logic      [calc_stages_gp-1:0]                    fwd_v;
  logic      [calc_stages_gp-1:0][reg_addr_width_gp-1:0] fwd_rd_addr;
  logic      [calc_stages_gp-1:0][dword_width_gp-1:0]    fwd_data;

  logic [dword_width_gp-1:0]    bypass_rs1, bypass_rs2;
  logic [dword_width_gp-1:0]    int_data, mul_data, wb_data;
  logic                         int_done, mul_done;
  logic                         wb_w_v;
  logic [reg_addr_width_gp-1:0] wb_rd_addr;

  // Control from the stage pipe, data from the completion pipe
  always_comb
  begin
    for (int i = 0; i < calc_stages_gp; i++)
    begin
      fwd[i].v       = fwd_v[i];
      fwd[i].rd_addr = fwd_rd_addr[i];
      fwd[i].data    = fwd_data[i];
    end
  end

  calc_bypass
    #(.depth_p(calc_stages_gp), .zero_x0_p(1'b1))
  int_bypass
    (.rs1_addr_i(dispatch_pkt_i.rs1_addr)
    ,.rs2_addr_i(dispatch_pkt_i.rs2_addr)
    ,.rs1_i(dispatch_pkt_i.rs1)
    ,.rs2_i(dispatch_pkt_i.rs2)
    ,.fwd_i(fwd)
    ,.rs1_o(bypass_rs1)
    ,.rs2_o(bypass_rs2)
    );

  always_comb
  begin
    reservation_n     = dispatch_pkt_i;
    reservation_n.rs1 = bypass_rs1;
    reservation_n.rs2 = bypass_rs2;
  end

  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
  end

  calc_pipe_int pipe_int
    (.decode_i(reservation_r.decode)
    ,.rs1_i(reservation_r.rs1)
    ,.rs2_i(reservation_r.rs2)
    ,.imm_i(reservation_r.imm)
    ,.data_o(int_data)
    );

  // Registers its own copy of the bypassed operands
  calc_pipe_mul pipe_mul
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.rs1_i(reservation_n.rs1)
    ,.rs2_i(reservation_n.rs2)
    ,.data_o(mul_data)
    );

  calc_stage_pipe stage_pipe
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.dispatch_pkt_i(reservation_n)
    ,.flush_i(flush_i)
    ,.fwd_v_o(fwd_v)
    ,.fwd_rd_addr_o(fwd_rd_addr)
    ,.int_done_o(int_done)
    ,.mul_done_o(mul_done)
    ,.status_o(calc_status_o)
    ,.commit_o(commit_pkt_o)
    ,.wb_w_v_o(wb_w_v)
    ,.wb_rd_addr_o(wb_rd_addr)
    );

  calc_comp_pipe comp_pipe
    (.clk_i(clk_i)
    ,.int_data_i(int_data)
    ,.mul_data_i(mul_data)
    ,.int_done_i(int_done)
    ,.mul_done_i(mul_done)
    ,.fwd_data_o(fwd_data)
    ,.wb_data_o(wb_data)
    );

  assign wb_pkt_o.rd_w_v  = wb_w_v;
  assign wb_pkt_o.rd_addr = wb_rd_addr;
  assign wb_pkt_o.rd_data = wb_data;

endmodule

`default_nettype wire

// File: calculator_asserts.sv
// ------------------------------
// Concurrent checks bound to the top
// Reset is synchronous, active high
// ------------------------------
`default_nettype none

module calculator_asserts
  import calc_pkg::*;
  (
    input  logic             clk_i
  , input  logic             reset_i
  , input  logic             int_done_i
  , input  logic             mul_done_i
  , input  calc_commit_pkt_s commit_pkt_i
  , input  calc_wb_pkt_s     wb_pkt_i
  );

  // Pipes are cleared by the reset just released
  assert property (@(posedge clk_i) $fell(reset_i) |-> !commit_pkt_i.v && !wb_pkt_i.rd_w_v)
    else $error("commit or writeback valid set right after reset");

  // An item that finished in the ALU must not also finish in the multiplier
  assert property (@(posedge clk_i) disable iff (reset_i) int_done_i |=> !mul_done_i)
    else $error("one item completed in both pipes");

  assert property (@(posedge clk_i) disable iff (reset_i)
                   wb_pkt_i.rd_w_v |-> (wb_pkt_i.rd_addr != '0))
    else $error("register 0 written back");

endmodule

bind calculator_top calculator_asserts asserts
  (.clk_i(clk_i)
  ,.reset_i(reset_i)
  ,.int_done_i(int_done)
  ,.mul_done_i(mul_done)
  ,.commit_pkt_i(commit_pkt_o)
  ,.wb_pkt_i(wb_pkt_o)
  );

`default_nettype wire

// File: tb_clk_gen.sv
// ------------------------------
// Testbench clock and reset
// Period 10, reset held for two edges
// ------------------------------
`default_nettype none

module tb_clk_gen
  (
    output logic clk_o
  , output logic reset_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Released a little after the second rising edge
  initial
  begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: calculator_tb.sv
// ------------------------------
// Directed tests for the execute core
// Outputs are checked every cycle
// Consumers of a multiply wait one slot
// ------------------------------
`default_nettype none

module calculator_tb
  import calc_pkg::*;
  ();

  // One dispatch slot per cycle over all tests
  localparam int test_cycles_lp = 111;
  localparam int timeout_lp     = test_cycles_lp * 10 + 500;

  // Reference view of one dispatch slot
  typedef struct packed
  {
    logic                         v;
    logic                         poison;
    logic [pc_width_gp-1:0]       pc;
    logic [reg_addr_width_gp-1:0] rd;
    logic                         int_v;
    logic                         mul_v;
    logic [dword_width_gp-1:0]    result;
  } item_s;

  logic               clk, reset, flush;
  calc_dispatch_pkt_s dispatch_pkt;
  calc_status_s       status;
  calc_commit_pkt_s   commit;
  calc_wb_pkt_s       wb;

  item_s                     hist [calc_stages_gp];
  logic [dword_width_gp-1:0] arch [32];
  logic [dword_width_gp-1:0] rf [32];
  logic [31:0]               rng_state;
  logic [pc_width_gp-1:0]    next_pc;

  tb_clk_gen clk_gen (.clk_o(clk), .reset_o(reset));

  calculator_top DUT
    (.clk_i(clk)
    ,.reset_i(reset)
    ,.dispatch_pkt_i(dispatch_pkt)
    ,.flush_i(flush)
    ,.calc_status_o(status)
    ,.commit_pkt_o(commit)
    ,.wb_pkt_o(wb)
    );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic rand64(output logic [dword_width_gp-1:0] r);
    rng_state = xorshift32(rng_state);
    r[63:32]  = rng_state;
    rng_state = xorshift32(rng_state);
    r[31:0]   = rng_state;
  endtask

  function automatic logic [dword_width_gp-1:0] alu_ref
    (input calc_int_op_e op, input logic [63:0] a, input logic [63:0] b);
    case (op)
      e_int_add: return a + b;
      e_int_sub: return a - b;
      e_int_and: return a & b;
      e_int_or:  return a | b;
      e_int_xor: return a ^ b;
      e_int_slt: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      e_int_sll: return a << b[5:0];
      default:   return a >> b[5:0];
    endcase
  endfunction

  task automatic fail_now(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_wb(input calc_wb_pkt_s exp, input calc_wb_pkt_s act, input logic with_data);
    if (exp.rd_w_v !== act.rd_w_v || exp.rd_addr !== act.rd_addr
        || (with_data && exp.rd_data !== act.rd_data))
      fail_now($sformatf("wb exp w=%b rd=%0d d=%h got w=%b rd=%0d d=%h", exp.rd_w_v,
               exp.rd_addr, exp.rd_data, act.rd_w_v, act.rd_addr, act.rd_data));
  endtask

  task automatic check_commit(input calc_commit_pkt_s exp, input calc_commit_pkt_s act);
    if (exp !== act)
      fail_now($sformatf("commit exp v=%b ir=%b pc=%h npc=%h got v=%b ir=%b pc=%h npc=%h",
               exp.v, exp.instret, exp.pc, exp.npc, act.v, act.instret, act.pc, act.npc));
  endtask

  task automatic check_dep(input int idx, input calc_dep_status_s exp, input calc_dep_status_s act);
    if (exp !== act)
      fail_now($sformatf("dep status stage %0d exp %b got %b", idx, exp, act));
  endtask

  // All outputs follow from the last four slots
  task automatic check_outputs();
    calc_dep_status_s dep_exp;
    calc_commit_pkt_s commit_exp;
    calc_wb_pkt_s     wb_exp;
    logic             live;
    for (int i = 0; i < calc_stages_gp; i++)
    begin
      live              = hist[i].v & ~hist[i].poison;
      dep_exp.v         = live;
      dep_exp.int_iwb_v = live & hist[i].int_v & (hist[i].rd != '0);
      dep_exp.mul_iwb_v = live & hist[i].mul_v & (hist[i].rd != '0);
      dep_exp.rd_addr   = hist[i].rd;
      check_dep(i, dep_exp, status.dep_status[i]);
    end
    if (status.ex1_v !== (hist[0].v & ~hist[0].poison))
      fail_now("ex1_v status wrong");
    live               = hist[2].v & ~hist[2].poison;
    commit_exp.v       = live;
    commit_exp.instret = live & (hist[2].int_v | hist[2].mul_v);
    commit_exp.pc      = hist[2].pc;
    commit_exp.npc     = hist[1].pc;
    check_commit(commit_exp, commit);
    wb_exp.rd_w_v  = hist[3].v & ~hist[3].poison & (hist[3].rd != '0);
    wb_exp.rd_addr = hist[3].rd;
    wb_exp.rd_data = hist[3].result;
    check_wb(wb_exp, wb, wb_exp.rd_w_v);
    if (wb_exp.rd_w_v)
      rf[wb_exp.rd_addr] = wb_exp.rd_data;
  endtask

  task automatic step(input calc_dispatch_pkt_s pkt, input item_s item, input logic flush_v);
    dispatch_pkt = pkt;
    flush        = flush_v;
    @(posedge clk);
    for (int i = calc_stages_gp-1; i > 0; i--)
      hist[i] = hist[i-1];
    hist[0] = item;
    // Flush kills the newest three slots
    if (flush_v)
      for (int i = 0; i < 3; i++)
        hist[i].poison = 1'b1;
    #1;
    check_outputs();
  endtask

  // Operands are read from the lagging register file, stale values included
  task automatic issue_op(input logic mul, input calc_int_op_e op, input logic use_imm,
                          input int rd, input int rs1a, input int rs2a,
                          input logic [63:0] imm, input logic poison_v, input logic v,
                          input logic flush_v);
    calc_dispatch_pkt_s pkt;
    item_s              item;
    logic [63:0]        a, b;
    a   = (rs1a == 0) ? '0 : arch[rs1a];
    b   = (rs2a == 0) ? '0 : arch[rs2a];
    pkt = '0;
    pkt.v                 = v;
    pkt.poison            = poison_v;
    pkt.pc                = next_pc;
    pkt.rs1_addr          = rs1a;
    pkt.rs2_addr          = rs2a;
    pkt.rd_addr           = rd;
    pkt.decode.pipe_int_v = ~mul;
    pkt.decode.pipe_mul_v = mul;
    pkt.decode.irf_w_v    = 1'b1;
    pkt.decode.instr_v    = 1'b1;
    pkt.decode.use_imm    = use_imm;
    pkt.decode.op         = op;
    pkt.rs1               = rf[rs1a];
    pkt.rs2               = rf[rs2a];
    pkt.imm               = imm;
    item        = '0;
    item.v      = v;
    item.poison = poison_v;
    item.pc     = next_pc;
    item.rd     = rd;
    item.int_v  = v & ~mul;
    item.mul_v  = v & mul;
    item.result = mul ? a * b : alu_ref(op, a, use_imm ? imm : b);
    if (v && !poison_v && rd != 0)
      arch[rd] = item.result;
    next_pc = next_pc + 4;
    step(pkt, item, flush_v);
  endtask

  task automatic alu(input calc_int_op_e op, input int rd, input int rs1a, input int rs2a);
    issue_op(1'b0, op, 1'b0, rd, rs1a, rs2a, '0, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic alui(input calc_int_op_e op, input int rd, input int rs1a, input logic [63:0] imm);
    issue_op(1'b0, op, 1'b1, rd, rs1a, 0, imm, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic mul(input int rd, input int rs1a, input int rs2a);
    issue_op(1'b1, e_int_add, 1'b0, rd, rs1a, rs2a, '0, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic idle(input int n);
    calc_dispatch_pkt_s pkt;
    item_s              item;
    repeat (n)
    begin
      pkt     = '0;
      pkt.pc  = next_pc;
      item    = '0;
      item.pc = next_pc;
      next_pc = next_pc + 4;
      step(pkt, item, 1'b0);
    end
  endtask

  task automatic test_alu_ops();
    logic [63:0] a, b;
    for (int op = 0; op < 8; op++)
    begin
      for (int m = 0; m < 2; m++)
      begin
        rand64(a);
        rand64(b);
        alui(e_int_add, 1, 0, a);
        alui(e_int_add, 2, 0, b);
        if (m == 1)
          alui(calc_int_op_e'(op), 3, 1, b);
        else
          alu(calc_int_op_e'(op), 3, 1, 2);
      end
    end
  endtask

  task automatic test_mul();
    logic [63:0] a, b;
    repeat (3)
    begin
      rand64(a);
      rand64(b);
      alui(e_int_add, 4, 0, a);
      alui(e_int_add, 5, 0, b);
      mul(6, 4, 5);
      idle(4);
    end
  endtask

  task automatic test_bypass();
    logic [63:0] a;
    rand64(a);
    alui(e_int_add, 7, 0, a);
    repeat (3) alu(e_int_add, 7, 7, 7);
    mul(8, 7, 1);
    alu(e_int_xor, 9, 1, 2);
    // Multiply result taken from the EX2 slice
    alu(e_int_add, 10, 8, 1);
    alui(e_int_add, 0, 1, a);
    alui(e_int_add, 11, 0, 64'd5);
    idle(4);
  endtask

  task automatic test_flush();
    logic [63:0] a, b;
    rand64(a);
    rand64(b);
    alui(e_int_add, 12, 0, a);
    alui(e_int_add, 13, 0, b);
    alu(e_int_add, 12, 12, 12);
    issue_op(1'b0, e_int_or, 1'b1, 14, 12, 0, b, 1'b0, 1'b1, 1'b1);
    idle(4);
    // Drop the speculative writes of the flushed items
    for (int r = 0; r < 32; r++)
      arch[r] = rf[r];
    alu(e_int_add, 15, 12, 13);
    idle(4);
  endtask

  task automatic test_poison_invalid();
    logic [63:0] a, b;
    rand64(a);
    rand64(b);
    alui(e_int_add, 16, 0, a);
    issue_op(1'b0, e_int_add, 1'b1, 16, 0, 0, b, 1'b1, 1'b1, 1'b0);
    alui(e_int_add, 17, 16, '0);
    issue_op(1'b0, e_int_add, 1'b1, 16, 0, 0, b, 1'b0, 1'b0, 1'b0);
    alu(e_int_add, 18, 16, 0);
    idle(4);
  endtask

  // Holds the consumer back as the issue checker would
  task automatic test_dep_hold();
    int guard;
    guard = 0;
    mul(19, 1, 2);
    while (status.dep_status[0].mul_iwb_v && status.dep_status[0].rd_addr == 19)
    begin
      idle(1);
      guard++;
      if (guard > 4)
        fail_now("multiply hazard in status never cleared");
    end
    alu(e_int_add, 20, 19, 1);
    idle(4);
  endtask

  initial
  begin
    dispatch_pkt = '0;
    flush        = 1'b0;
    rng_state    = 32'h1b31d27a;
    next_pc      = 39'h100;
    for (int r = 0; r < 32; r++)
    begin
      arch[r] = '0;
      rf[r]   = '0;
    end
    for (int i = 0; i < calc_stages_gp; i++)
      hist[i] = '0;
    @(negedge reset);
    test_alu_ops();
    test_mul();
    test_bypass();
    test_flush();
    test_poison_invalid();
    test_dep_hold();
    $display("All checks passed");
    $finish;
  end

  initial
  begin
    #(timeout_lp);
    $display("Watchdog expired before the tests finished");
    $display("Checks failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: src.f
calc_pkg.sv
calc_bypass.sv
calc_pipe_int.sv
calc_pipe_mul.sv
calc_stage_pipe.sv
calc_comp_pipe.sv
calculator_top.sv
calculator_asserts.sv
tb_clk_gen.sv
calculator_tb.sv
